//--- design/fmap_pkg.sv
`default_nettype none

package fmap_pkg;

	// ****************************************
	// Buffer geometry
	// ****************************************
	localparam int FMAP_SIZE  = 5;
	localparam int NUM_UNITS  = 3;
	localparam int NUM_BANKS  = 4;
	localparam int DATA_WIDTH = 32;
	localparam int DEPTH      = FMAP_SIZE * FMAP_SIZE;
	localparam int ADDR_WIDTH = $clog2(DEPTH);
	localparam int BANK_WIDTH = $clog2(NUM_BANKS);

	// Read paths seen by the router
	localparam int RD_PATHS    = 3;
	localparam int PATH_PREV   = 0;
	localparam int PATH_NEXT_A = 1;
	localparam int PATH_NEXT_B = 2;

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [BANK_WIDTH-1:0] bank_idx_t;

	// One word per parallel channel
	typedef word_t word_vec_t [NUM_UNITS];

endpackage

`default_nettype wire

//--- design/fmap_bank_ptr.sv
`default_nettype none

module fmap_bank_ptr
	import fmap_pkg::*;
(
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic bank_advance,
	output bank_idx_t bank_sel
);

	bank_idx_t bank_next;
	logic      at_last;

	// Wrap after the last bank of the ring
	assign at_last = (bank_sel == bank_idx_t'(NUM_BANKS - 1));

	always_comb
	begin
		if (at_last)
			bank_next = '0;
		else
			bank_next = bank_sel + 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bank_sel <= '0;
		end
		else if (bank_advance)
		begin
			bank_sel <= bank_next;
		end
	end

endmodule

`default_nettype wire

//--- design/fmap_bank.sv
`default_nettype none

module fmap_bank
	import fmap_pkg::*;
(
	input  wire logic clk,
	input  wire logic arst_n,

	// Port A, write or read
	input  wire logic a_wr_en,
	input  wire logic a_rd_en,
	input  addr_t     a_addr,
	input  word_vec_t a_wr_data,

	// Port B, read only
	input  wire logic b_rd_en,
	input  addr_t     b_addr,

	output word_vec_t a_rd_data,
	output word_vec_t b_rd_data
);

	// ****************************************
	// One dual-port memory per channel
	// ****************************************
	for (genvar u = 0; u < NUM_UNITS; u++)
	begin : g_unit
		word_t mem [DEPTH];

		always_ff @(posedge clk)
		begin
			if (a_wr_en)
			begin
				mem[a_addr] <= a_wr_data[u];
			end
		end

		// Registered outputs, loaded only on a read
		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				a_rd_data[u] <= '0;
			end
			else if (a_rd_en)
			begin
				a_rd_data[u] <= mem[a_addr];
			end
		end

		// Sees the old word if port A writes the same address
		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				b_rd_data[u] <= '0;
			end
			else if (b_rd_en)
			begin
				b_rd_data[u] <= mem[b_addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/fmap_port_route.sv
`default_nettype none

module fmap_port_route
	import fmap_pkg::*;
(
	input  wire logic clk,
	input  wire logic arst_n,
	input  bank_idx_t bank_sel,

	// Previous layer
	input  wire logic wr_en,
	input  addr_t     wr_addr,
	input  word_vec_t wr_data,
	input  wire logic prev_rd_en,
	input  addr_t     prev_rd_addr,

	// Next layer
	input  wire logic next_rd_a_en,
	input  addr_t     next_rd_a_addr,
	input  wire logic next_rd_b_en,
	input  addr_t     next_rd_b_addr,

	// Requests to the banks
	output logic      bank_a_wr_en   [NUM_BANKS],
	output logic      bank_a_rd_en   [NUM_BANKS],
	output addr_t     bank_a_addr    [NUM_BANKS],
	output word_vec_t bank_a_wr_data [NUM_BANKS],
	output logic      bank_b_rd_en   [NUM_BANKS],
	output addr_t     bank_b_addr    [NUM_BANKS],

	// Words coming back from the banks
	input  word_vec_t bank_a_rd_data [NUM_BANKS],
	input  word_vec_t bank_b_rd_data [NUM_BANKS],

	output word_vec_t prev_rd_data,
	output word_vec_t next_rd_a_data,
	output word_vec_t next_rd_b_data
);

	bank_idx_t prv_bank;

	logic      path_en     [RD_PATHS];
	bank_idx_t path_bank   [RD_PATHS];
	logic      path_en_q   [RD_PATHS];
	bank_idx_t path_bank_q [RD_PATHS];
	word_vec_t path_src    [RD_PATHS];
	word_vec_t path_hold_q [RD_PATHS];
	word_vec_t path_data   [RD_PATHS];

	// Next layer reads the bank behind the current one
	assign prv_bank = (bank_sel == '0) ? bank_idx_t'(NUM_BANKS - 1) : bank_sel - 1'b1;

	// ****************************************
	// Request steering
	// ****************************************
	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			bank_a_wr_en[b]   = wr_en && (bank_idx_t'(b) == bank_sel);
			bank_a_rd_en[b]   = next_rd_a_en && (bank_idx_t'(b) == prv_bank);
			bank_a_addr[b]    = (bank_idx_t'(b) == bank_sel) ? wr_addr : next_rd_a_addr;
			bank_a_wr_data[b] = wr_data;
			bank_b_rd_en[b]   = (prev_rd_en && (bank_idx_t'(b) == bank_sel))
				|| (next_rd_b_en && (bank_idx_t'(b) == prv_bank));
			bank_b_addr[b]    = (bank_idx_t'(b) == bank_sel) ? prev_rd_addr : next_rd_b_addr;
		end
	end

	// ****************************************
	// Return select
	// ****************************************
	assign path_en[PATH_PREV]     = prev_rd_en;
	assign path_en[PATH_NEXT_A]   = next_rd_a_en;
	assign path_en[PATH_NEXT_B]   = next_rd_b_en;
	assign path_bank[PATH_PREV]   = bank_sel;
	assign path_bank[PATH_NEXT_A] = prv_bank;
	assign path_bank[PATH_NEXT_B] = prv_bank;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int p = 0; p < RD_PATHS; p++)
			begin
				path_en_q[p]   <= 1'b0;
				path_bank_q[p] <= '0;
				path_hold_q[p] <= '{default: '0};
			end
		end
		else
		begin
			for (int p = 0; p < RD_PATHS; p++)
			begin
				path_en_q[p] <= path_en[p];
				if (path_en[p])
					path_bank_q[p] <= path_bank[p];
				// Keep the word so a later read on the shared port cannot disturb it
				if (path_en_q[p])
					path_hold_q[p] <= path_src[p];
			end
		end
	end

	always_comb
	begin
		path_src[PATH_PREV]   = bank_b_rd_data[path_bank_q[PATH_PREV]];
		path_src[PATH_NEXT_A] = bank_a_rd_data[path_bank_q[PATH_NEXT_A]];
		path_src[PATH_NEXT_B] = bank_b_rd_data[path_bank_q[PATH_NEXT_B]];
		for (int p = 0; p < RD_PATHS; p++)
		begin
			path_data[p] = path_en_q[p] ? path_src[p] : path_hold_q[p];
		end
	end

	assign prev_rd_data   = path_data[PATH_PREV];
	assign next_rd_a_data = path_data[PATH_NEXT_A];
	assign next_rd_b_data = path_data[PATH_NEXT_B];

endmodule

`default_nettype wire

//--- design/fmap_buffer.sv
`default_nettype none

module fmap_buffer
	import fmap_pkg::*;
(
	input  wire logic clk,
	input  wire logic arst_n,

	// Previous layer
	input  wire logic wr_en,
	input  addr_t     wr_addr,
	input  word_vec_t wr_data,
	input  wire logic prev_rd_en,
	input  addr_t     prev_rd_addr,
	output word_vec_t prev_rd_data,

	// Next layer
	input  wire logic next_rd_a_en,
	input  addr_t     next_rd_a_addr,
	output word_vec_t next_rd_a_data,
	input  wire logic next_rd_b_en,
	input  addr_t     next_rd_b_addr,
	output word_vec_t next_rd_b_data,

	// Rotation control
	input  wire logic bank_advance,
	output bank_idx_t bank_sel
);

	logic      bank_a_wr_en   [NUM_BANKS];
	logic      bank_a_rd_en   [NUM_BANKS];
	addr_t     bank_a_addr    [NUM_BANKS];
	word_vec_t bank_a_wr_data [NUM_BANKS];
	logic      bank_b_rd_en   [NUM_BANKS];
	addr_t     bank_b_addr    [NUM_BANKS];
	word_vec_t bank_a_rd_data [NUM_BANKS];
	word_vec_t bank_b_rd_data [NUM_BANKS];

	fmap_bank_ptr u_bank_ptr (
		.clk          (clk),
		.arst_n       (arst_n),
		.bank_advance (bank_advance),
		.bank_sel     (bank_sel)
	);

	fmap_port_route u_port_route (
		.clk            (clk),
		.arst_n         (arst_n),
		.bank_sel       (bank_sel),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.prev_rd_en     (prev_rd_en),
		.prev_rd_addr   (prev_rd_addr),
		.next_rd_a_en   (next_rd_a_en),
		.next_rd_a_addr (next_rd_a_addr),
		.next_rd_b_en   (next_rd_b_en),
		.next_rd_b_addr (next_rd_b_addr),
		.bank_a_wr_en   (bank_a_wr_en),
		.bank_a_rd_en   (bank_a_rd_en),
		.bank_a_addr    (bank_a_addr),
		.bank_a_wr_data (bank_a_wr_data),
		.bank_b_rd_en   (bank_b_rd_en),
		.bank_b_addr    (bank_b_addr),
		.bank_a_rd_data (bank_a_rd_data),
		.bank_b_rd_data (bank_b_rd_data),
		.prev_rd_data   (prev_rd_data),
		.next_rd_a_data (next_rd_a_data),
		.next_rd_b_data (next_rd_b_data)
	);

	// ****************************************
	// Ring of banks
	// ****************************************
	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		fmap_bank u_bank (
			.clk       (clk),
			.arst_n    (arst_n),
			.a_wr_en   (bank_a_wr_en[b]),
			.a_rd_en   (bank_a_rd_en[b]),
			.a_addr    (bank_a_addr[b]),
			.a_wr_data (bank_a_wr_data[b]),
			.b_rd_en   (bank_b_rd_en[b]),
			.b_addr    (bank_b_addr[b]),
			.a_rd_data (bank_a_rd_data[b]),
			.b_rd_data (bank_b_rd_data[b])
		);
	end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always
	begin
		#(PERIOD / 2);
		clk = ~clk;
	end

endmodule

`default_nettype wire

//--- test/fmap_buffer_props.sv
`default_nettype none

module fmap_buffer_props
	import fmap_pkg::*;
(
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic bank_advance,
	input  bank_idx_t bank_sel,
	input  wire logic prev_rd_en,
	input  wire logic next_rd_a_en,
	input  wire logic next_rd_b_en,
	input  word_vec_t prev_rd_data,
	input  word_vec_t next_rd_a_data,
	input  word_vec_t next_rd_b_data
);

	// ****************************************
	// Bank pointer
	// ****************************************
	a_ptr_step: assert property (@(posedge clk) disable iff (!arst_n)
		$past(bank_advance) |-> bank_sel == bank_idx_t'((int'($past(bank_sel)) + 1) % NUM_BANKS))
		else $error("bank_sel did not step by one after bank_advance");

	a_ptr_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!$past(bank_advance) |-> $stable(bank_sel))
		else $error("bank_sel moved without bank_advance");

	// ****************************************
	// Read outputs hold without a read
	// ****************************************
	for (genvar u = 0; u < NUM_UNITS; u++)
	begin : g_hold
		a_prev_hold: assert property (@(posedge clk) disable iff (!arst_n)
			!$past(prev_rd_en) |-> $stable(prev_rd_data[u]))
			else $error("prev_rd_data changed without a read");

		a_next_a_hold: assert property (@(posedge clk) disable iff (!arst_n)
			!$past(next_rd_a_en) |-> $stable(next_rd_a_data[u]))
			else $error("next_rd_a_data changed without a read");

		a_next_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
			!$past(next_rd_b_en) |-> $stable(next_rd_b_data[u]))
			else $error("next_rd_b_data changed without a read");
	end

endmodule

`default_nettype wire

//--- test/fmap_buffer_tb.sv
`default_nettype none

module fmap_buffer_tb
	import fmap_pkg::*;
();

	localparam int CLK_PERIOD    = 4;
	localparam int NEXT_READS    = 20;
	localparam int TEST_CYCLES   = 6 * DEPTH + 3 * NEXT_READS + 40;
	localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD;
	localparam logic [31:0] LFSR_SEED = 32'd88921;

	logic      clk;
	logic      arst_n;
	logic      wr_en;
	addr_t     wr_addr;
	word_vec_t wr_data;
	logic      prev_rd_en;
	addr_t     prev_rd_addr;
	word_vec_t prev_rd_data;
	logic      next_rd_a_en;
	addr_t     next_rd_a_addr;
	word_vec_t next_rd_a_data;
	logic      next_rd_b_en;
	addr_t     next_rd_b_addr;
	word_vec_t next_rd_b_data;
	logic      bank_advance;
	bank_idx_t bank_sel;

	// Model state
	word_t     model_mem [NUM_BANKS][NUM_UNITS][DEPTH];
	bank_idx_t model_bank;
	word_vec_t exp_prev;
	word_vec_t exp_a;
	word_vec_t exp_b;

	logic [31:0] lfsr_state = LFSR_SEED;
	bit          pass_reported = 1'b0;
	bit          fail_reported = 1'b0;

	tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

	fmap_buffer uut (
		.clk            (clk),
		.arst_n         (arst_n),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.prev_rd_en     (prev_rd_en),
		.prev_rd_addr   (prev_rd_addr),
		.prev_rd_data   (prev_rd_data),
		.next_rd_a_en   (next_rd_a_en),
		.next_rd_a_addr (next_rd_a_addr),
		.next_rd_a_data (next_rd_a_data),
		.next_rd_b_en   (next_rd_b_en),
		.next_rd_b_addr (next_rd_b_addr),
		.next_rd_b_data (next_rd_b_data),
		.bank_advance   (bank_advance),
		.bank_sel       (bank_sel)
	);

	bind fmap_buffer fmap_buffer_props u_props (
		.clk            (clk),
		.arst_n         (arst_n),
		.bank_advance   (bank_advance),
		.bank_sel       (bank_sel),
		.prev_rd_en     (prev_rd_en),
		.next_rd_a_en   (next_rd_a_en),
		.next_rd_b_en   (next_rd_b_en),
		.prev_rd_data   (prev_rd_data),
		.next_rd_a_data (next_rd_a_data),
		.next_rd_b_data (next_rd_b_data)
	);

	// ****************************************
	// Random source and reference model
	// ****************************************
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			val = {val[30:0], lfsr_state[31]};
			lfsr_state = {lfsr_state[30:0], fb};
		end
		return val;
	endfunction

	function automatic addr_t rand_addr();
		return addr_t'(take_bits(ADDR_WIDTH) % DEPTH);
	endfunction

	function automatic word_t ref_word(input bank_idx_t bank, input int unit, input addr_t addr);
		return model_mem[bank][unit][addr];
	endfunction

	// Next layer sees the bank behind the current one
	function automatic bank_idx_t prev_bank_of(input bank_idx_t bank);
		return bank_idx_t'((int'(bank) + NUM_BANKS - 1) % NUM_BANKS);
	endfunction

	// ****************************************
	// Compare tasks
	// ****************************************
	task automatic abort_run();
		fail_reported = 1'b1;
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_word(input string name, input int unit, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED: %s[%0d] got 0x%h expected 0x%h at time %0t",
				name, unit, got, exp, $time);
			abort_run();
		end
	endtask

	task automatic check_bank(input string name, input bank_idx_t got, input bank_idx_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h at time %0t",
				name, got, exp, $time);
			abort_run();
		end
	endtask

	// Expected values taken at the edge, before that edge's write
	always @(posedge clk)
	begin
		if (!arst_n)
		begin
			model_bank = '0;
			exp_prev   = '{default: '0};
			exp_a      = '{default: '0};
			exp_b      = '{default: '0};
		end
		else
		begin
			for (int u = 0; u < NUM_UNITS; u++)
			begin
				if (prev_rd_en)
					exp_prev[u] = ref_word(model_bank, u, prev_rd_addr);
				if (next_rd_a_en)
					exp_a[u] = ref_word(prev_bank_of(model_bank), u, next_rd_a_addr);
				if (next_rd_b_en)
					exp_b[u] = ref_word(prev_bank_of(model_bank), u, next_rd_b_addr);
				if (wr_en)
					model_mem[model_bank][u][wr_addr] = wr_data[u];
			end
			if (bank_advance)
				model_bank = bank_idx_t'((int'(model_bank) + 1) % NUM_BANKS);
		end
	end

	always @(negedge clk)
	begin
		if (arst_n)
		begin
			check_bank("bank_sel", bank_sel, model_bank);
			for (int u = 0; u < NUM_UNITS; u++)
			begin
				check_word("prev_rd_data", u, prev_rd_data[u], exp_prev[u]);
				check_word("next_rd_a_data", u, next_rd_a_data[u], exp_a[u]);
				check_word("next_rd_b_data", u, next_rd_b_data[u], exp_b[u]);
			end
		end
	end

	// ****************************************
	// Stimulus
	// ****************************************
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_strobes();
		wr_en        = 1'b0;
		prev_rd_en   = 1'b0;
		next_rd_a_en = 1'b0;
		next_rd_b_en = 1'b0;
		bank_advance = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step_cycle();
	endtask

	// Two different addresses for ports A and B
	task automatic set_next_reads();
		addr_t a_addr;
		addr_t b_addr;
		a_addr = rand_addr();
		b_addr = rand_addr();
		if (b_addr == a_addr)
			b_addr = addr_t'((int'(b_addr) + 1) % DEPTH);
		next_rd_a_en   = 1'b1;
		next_rd_a_addr = a_addr;
		next_rd_b_en   = 1'b1;
		next_rd_b_addr = b_addr;
	endtask

	task automatic fill_current_bank(input bit read_same, input bit with_next_reads);
		for (int a = 0; a < DEPTH; a++)
		begin
			wr_en = 1'b1;
			wr_addr = addr_t'(a);
			for (int u = 0; u < NUM_UNITS; u++)
				wr_data[u] = word_t'(take_bits(DATA_WIDTH));
			prev_rd_en   = read_same;
			prev_rd_addr = addr_t'(a);
			if (with_next_reads)
				set_next_reads();
			step_cycle();
		end
		clear_strobes();
	endtask

	task automatic read_back_prev(input int n);
		repeat (n)
		begin
			prev_rd_en   = 1'b1;
			prev_rd_addr = rand_addr();
			step_cycle();
		end
		clear_strobes();
	endtask

	task automatic next_reads(input int n);
		repeat (n)
		begin
			set_next_reads();
			step_cycle();
		end
		clear_strobes();
	endtask

	task automatic pulse_advance();
		bank_advance = 1'b1;
		step_cycle();
		bank_advance = 1'b0;
	endtask

	initial
	begin
		arst_n         = 1'b0;
		clear_strobes();
		wr_addr        = '0;
		wr_data        = '{default: '0};
		prev_rd_addr   = '0;
		next_rd_a_addr = '0;
		next_rd_b_addr = '0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		idle_cycles(3);

		// Fill bank 0, read back, then rewrite reading the old words
		fill_current_bank(1'b0, 1'b0);
		read_back_prev(DEPTH);
		fill_current_bank(1'b1, 1'b0);
		idle_cycles(2);

		// Bank 0 goes to the next layer
		pulse_advance();
		next_reads(NEXT_READS);

		// Writes into bank 1 while bank 0 is read
		fill_current_bank(1'b0, 1'b1);
		pulse_advance();
		idle_cycles(3);
		next_reads(NEXT_READS / 2);
		fill_current_bank(1'b0, 1'b1);
		pulse_advance();
		fill_current_bank(1'b0, 1'b1);

		// Fourth advance wraps the ring
		pulse_advance();
		check_bank("bank_sel", bank_sel, bank_idx_t'(0));
		next_reads(NEXT_READS);

		// Outputs hold across a rotation with no reads
		idle_cycles(3);
		pulse_advance();
		idle_cycles(3);

		pass_reported = 1'b1;
		$display("RESULT: PASS");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("Timeout: test did not finish within %0d time units", WATCHDOG_TIME);
		abort_run();
	end

	final
	begin
		if (!pass_reported && !fail_reported)
			$display("RESULT: FAIL");
	end

endmodule

`default_nettype wire

//--- verilog.f
design/fmap_pkg.sv
design/fmap_bank_ptr.sv
design/fmap_bank.sv
design/fmap_port_route.sv
design/fmap_buffer.sv
test/tb_clock.sv
test/fmap_buffer_props.sv
test/fmap_buffer_tb.sv

//--- Makefile
# Verilator flow for the feature-map buffer

VERILATOR  ?= verilator
TOP        ?= fmap_buffer_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
